//--- sdram_macros.svh
// ---------------------------------------------------------------------------
// Simulation defaults for a 16-bit SDR part. A real part needs T_INIT of
// 100 us and T_REFI of 7.8 us in clock cycles. CAS latency must be 2 or 3
// ---------------------------------------------------------------------------
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Bus and address field widths
`define SDRAM_DATA_W       16
`define SDRAM_ADDR_W       13
`define SDRAM_BANK_W       2
`define SDRAM_COL_W        9
`define SDRAM_ROW_W        13
`define SDRAM_USER_ADDR_W  24

// Timing counts in clock cycles
`define SDRAM_T_INIT       20
`define SDRAM_T_RP         2
`define SDRAM_T_RFC        7
`define SDRAM_T_MRD        2
`define SDRAM_T_RCD        2
`define SDRAM_T_WR         2
`define SDRAM_CAS_LAT      2
`define SDRAM_T_REFI       200
`define SDRAM_TIMER_W      16

// Mode register: single write, standard op, sequential, burst of one
`define SDRAM_MODE_WB_SINGLE  1'b1
`define SDRAM_MODE_OP_STD     2'b00
`define SDRAM_MODE_BT_SEQ     1'b0
`define SDRAM_MODE_BL_1       3'b000
`define SDRAM_MODE_WORD {3'b000, `SDRAM_MODE_WB_SINGLE, `SDRAM_MODE_OP_STD, \
    3'(`SDRAM_CAS_LAT), `SDRAM_MODE_BT_SEQ, `SDRAM_MODE_BL_1}

`endif

//--- sdram_pkg.sv
// ---------------------------------------------------------------------------
// Word address layout is row, bank, column from the top bit down
// ---------------------------------------------------------------------------
`include "sdram_macros.svh"

package sdram_pkg;

    typedef logic [`SDRAM_DATA_W-1:0]      data_t;
    typedef logic [`SDRAM_USER_ADDR_W-1:0] user_addr_t;
    typedef logic [`SDRAM_ROW_W-1:0]       row_t;
    typedef logic [`SDRAM_BANK_W-1:0]      bank_t;
    typedef logic [`SDRAM_COL_W-1:0]       col_t;

    // Commands from the datasheet truth table, DQM and burst stop not used
    typedef enum logic [2:0] {
        INHIBIT,
        NOP,
        ACTIVE,
        READ,
        WRITE,
        PRECHARGE_ALL,
        AUTO_REFRESH,
        LOAD_MODE
    } sdram_cmd_t;

    // Address field extraction
    function automatic row_t addr_row(user_addr_t addr);
        return addr[`SDRAM_USER_ADDR_W-1 -: `SDRAM_ROW_W];
    endfunction

    function automatic bank_t addr_bank(user_addr_t addr);
        return addr[`SDRAM_COL_W +: `SDRAM_BANK_W];
    endfunction

    function automatic col_t addr_col(user_addr_t addr);
        return addr[`SDRAM_COL_W-1:0];
    endfunction

endpackage

//--- sdram_req_capture.sv
// ---------------------------------------------------------------------------
// Request fields must be stable while cmd_ready waits for accept
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_req_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  accept,
    input  sdram_pkg::user_addr_t addr,
    input  sdram_pkg::data_t      wr_data,
    input  logic                  cmd_ready,
    output sdram_pkg::user_addr_t cur_addr,
    output sdram_pkg::data_t      cur_wr_data,
    output logic                  row_miss
);
    import sdram_pkg::*;

    logic row_valid;

    // Accepted request, used by READ and WRITE on the next cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_addr    <= addr;
            cur_wr_data <= wr_data;
        end
    end

    // Nothing captured yet after reset, so any request misses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_valid <= 1'b0;
        end else if (accept) begin
            row_valid <= 1'b1;
        end
    end

    // Waiting request against the row and bank held open
    assign row_miss = cmd_ready && (!row_valid
                                    || addr_row(addr) != addr_row(cur_addr)
                                    || addr_bank(addr) != addr_bank(cur_addr));

endmodule

//--- sdram_refresh_timer.sv
// ---------------------------------------------------------------------------
// Owed refreshes saturate at 7; the interval runs only after init
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_refresh_timer (
    input  logic clk,
    input  logic reset,
    input  logic init_done,
    input  logic refresh_start,
    output logic refresh_pending
);
    localparam int INT_W = $clog2(`SDRAM_T_REFI);

    logic [INT_W-1:0] interval;
    logic [2:0]       owed;
    logic             expire;

    assign expire = init_done && (interval == '0);

    // Interval counter, one expiry every T_REFI cycles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interval <= INT_W'(`SDRAM_T_REFI - 1);
        end else if (expire) begin
            interval <= INT_W'(`SDRAM_T_REFI - 1);
        end else if (init_done) begin
            interval <= interval - 1'b1;
        end
    end

    // Expiry and refresh in the same cycle cancel out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owed <= '0;
        end else if (expire && !refresh_start && owed != '1) begin
            owed <= owed + 1'b1;
        end else if (refresh_start && !expire) begin
            owed <= owed - 1'b1;
        end
    end

    assign refresh_pending = (owed != '0);

    a_refresh_owed: assert property (@(posedge clk) disable iff (reset)
        refresh_start |-> owed != '0)
        else $error("refresh started with no refresh owed");

endmodule

//--- sdram_ctrl_fsm.sv
// ---------------------------------------------------------------------------
// Single-word accesses only; every row change precharges all banks
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_ctrl_fsm (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  access,
    input  logic                  cmd_ready,
    input  logic                  wr_nrd,
    input  logic                  row_miss,
    input  logic                  refresh_pending,
    output sdram_pkg::sdram_cmd_t cmd,
    output logic                  cmd_accepted,
    output logic                  refresh_start,
    output logic                  init_done
);
    import sdram_pkg::*;

    typedef enum logic [3:0] {
        ST_INIT_WAIT, ST_INIT_PRECHARGE, ST_INIT_REFRESH1, ST_INIT_REFRESH2,
        ST_LOAD_MODE, ST_IDLE, ST_REFRESH, ST_ACTIVATE,
        ST_READ, ST_WRITE, ST_READ_DRAIN, ST_WRITE_RECOVER,
        ST_ROW_OPEN, ST_PRECHARGE
    } state_t;

    state_t                    state;
    state_t                    next_state;
    logic [`SDRAM_TIMER_W-1:0] timer;
    logic [`SDRAM_TIMER_W-1:0] timer_load;
    logic                      entry;
    logic                      timer_done;

    assign timer_done = (timer == '0);

    // -----------------------------------------------------------------------
    // Next state
    // -----------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_INIT_WAIT:      if (timer_done) next_state = ST_INIT_PRECHARGE;
            ST_INIT_PRECHARGE: if (timer_done) next_state = ST_INIT_REFRESH1;
            ST_INIT_REFRESH1:  if (timer_done) next_state = ST_INIT_REFRESH2;
            ST_INIT_REFRESH2:  if (timer_done) next_state = ST_LOAD_MODE;
            ST_LOAD_MODE:      if (timer_done) next_state = ST_IDLE;
            ST_IDLE: begin
                // Refresh wins over a waiting request
                if (refresh_pending) begin
                    next_state = ST_REFRESH;
                end else if (cmd_ready) begin
                    next_state = ST_ACTIVATE;
                end
            end
            ST_REFRESH:        if (timer_done) next_state = ST_IDLE;
            ST_ACTIVATE:       if (timer_done) next_state = wr_nrd ? ST_WRITE : ST_READ;
            ST_READ:           next_state = ST_READ_DRAIN;
            ST_WRITE:          next_state = ST_WRITE_RECOVER;
            ST_READ_DRAIN:     if (timer_done) next_state = ST_ROW_OPEN;
            ST_WRITE_RECOVER:  if (timer_done) next_state = ST_ROW_OPEN;
            ST_ROW_OPEN: begin
                if (refresh_pending || !access || (cmd_ready && row_miss)) begin
                    next_state = ST_PRECHARGE;
                end else if (cmd_ready) begin
                    next_state = wr_nrd ? ST_WRITE : ST_READ;
                end
            end
            ST_PRECHARGE:      if (timer_done) next_state = ST_IDLE;
            default:           next_state = ST_IDLE;
        endcase
    end

    // Delay for the state being entered; drain states count after their command
    always_comb begin
        case (next_state)
            ST_INIT_WAIT:      timer_load = `SDRAM_TIMER_W'(`SDRAM_T_INIT);
            ST_INIT_PRECHARGE,
            ST_PRECHARGE:      timer_load = `SDRAM_TIMER_W'(`SDRAM_T_RP);
            ST_INIT_REFRESH1,
            ST_INIT_REFRESH2,
            ST_REFRESH:        timer_load = `SDRAM_TIMER_W'(`SDRAM_T_RFC);
            ST_LOAD_MODE:      timer_load = `SDRAM_TIMER_W'(`SDRAM_T_MRD);
            ST_ACTIVATE:       timer_load = `SDRAM_TIMER_W'(`SDRAM_T_RCD);
            ST_READ_DRAIN:     timer_load = `SDRAM_TIMER_W'(`SDRAM_CAS_LAT - 1);
            ST_WRITE_RECOVER:  timer_load = `SDRAM_TIMER_W'(`SDRAM_T_WR - 1);
            default:           timer_load = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_INIT_WAIT;
            timer <= `SDRAM_TIMER_W'(`SDRAM_T_INIT);
            entry <= 1'b1;
        end else begin
            state <= next_state;
            entry <= (next_state != state);
            if (next_state != state) begin
                timer <= timer_load;
            end else if (!timer_done) begin
                timer <= timer - 1'b1;
            end
        end
    end

    // -----------------------------------------------------------------------
    // Command of the cycle, issued on entry and NOP while the timer runs
    // -----------------------------------------------------------------------
    always_comb begin
        case (state)
            ST_INIT_WAIT:      cmd = INHIBIT;
            ST_INIT_PRECHARGE,
            ST_PRECHARGE:      cmd = entry ? PRECHARGE_ALL : NOP;
            ST_INIT_REFRESH1,
            ST_INIT_REFRESH2,
            ST_REFRESH:        cmd = entry ? AUTO_REFRESH : NOP;
            ST_LOAD_MODE:      cmd = entry ? LOAD_MODE : NOP;
            ST_ACTIVATE:       cmd = entry ? ACTIVE : NOP;
            ST_READ:           cmd = READ;
            ST_WRITE:          cmd = WRITE;
            default:           cmd = NOP;
        endcase
    end

    assign cmd_accepted  = (next_state == ST_READ) || (next_state == ST_WRITE);
    assign refresh_start = (state == ST_REFRESH) && entry;
    assign init_done     = !(state inside {ST_INIT_WAIT, ST_INIT_PRECHARGE,
                                           ST_INIT_REFRESH1, ST_INIT_REFRESH2,
                                           ST_LOAD_MODE});

    a_accept_ready: assert property (@(posedge clk) disable iff (reset)
        cmd_accepted |-> cmd_ready)
        else $error("cmd_accepted without cmd_ready");

endmodule

//--- sdram_cmd_encoder.sv
// ---------------------------------------------------------------------------
// No auto-precharge; DQM and CKE are tied on the board
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_cmd_encoder (
    input  sdram_pkg::sdram_cmd_t    cmd,
    input  sdram_pkg::user_addr_t    req_addr,
    input  sdram_pkg::user_addr_t    cur_addr,
    input  sdram_pkg::data_t         cur_wr_data,
    output logic                     ncs,
    output logic                     nras,
    output logic                     ncas,
    output logic                     nwe,
    output logic [`SDRAM_ADDR_W-1:0] a,
    output sdram_pkg::bank_t         ba,
    output sdram_pkg::data_t         dq_out,
    output logic                     dq_oe
);
    import sdram_pkg::*;

    // CS#, RAS#, CAS#, WE#
    logic [3:0] pins;

    always_comb begin
        pins = 4'b1111;
        a    = '0;
        ba   = '0;
        case (cmd)
            INHIBIT:       pins = 4'b1111;
            NOP:           pins = 4'b0111;
            ACTIVE: begin
                pins = 4'b0011;
                a    = `SDRAM_ADDR_W'(addr_row(req_addr));
                ba   = addr_bank(req_addr);
            end
            READ: begin
                pins = 4'b0101;
                a    = `SDRAM_ADDR_W'(addr_col(cur_addr));
                ba   = addr_bank(cur_addr);
            end
            WRITE: begin
                pins = 4'b0100;
                a    = `SDRAM_ADDR_W'(addr_col(cur_addr));
                ba   = addr_bank(cur_addr);
            end
            PRECHARGE_ALL: begin
                pins  = 4'b0010;
                // A10 high selects all banks
                a[10] = 1'b1;
            end
            AUTO_REFRESH:  pins = 4'b0001;
            LOAD_MODE: begin
                pins = 4'b0000;
                a    = `SDRAM_MODE_WORD;
            end
            default:       pins = 4'b1111;
        endcase
    end

    assign {ncs, nras, ncas, nwe} = pins;

    assign dq_oe  = (cmd == WRITE);
    assign dq_out = dq_oe ? cur_wr_data : '0;

endmodule

//--- sdram_read_return.sv
// ---------------------------------------------------------------------------
// Expects SDRAM_CAS_LAT of 2 or 3; rd_data is zero outside cmd_done
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_read_return (
    input  logic                  clk,
    input  logic                  reset,
    input  sdram_pkg::sdram_cmd_t cmd,
    input  sdram_pkg::data_t      dq_in,
    output sdram_pkg::data_t      rd_data,
    output logic                  cmd_done
);
    import sdram_pkg::*;

    logic [`SDRAM_CAS_LAT-1:0] valid_pipe;
    logic                      rd_valid;

    // One stage per cycle of CAS latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`SDRAM_CAS_LAT-2:0], cmd == READ};
        end
    end

    assign rd_valid = valid_pipe[`SDRAM_CAS_LAT-1];
    assign rd_data  = rd_valid ? dq_in : '0;
    // Writes finish when the command is on the pins
    assign cmd_done = rd_valid || (cmd == WRITE);

endmodule

//--- sdram_ctrl.sv
// ---------------------------------------------------------------------------
// SDR SDRAM controller, one word per access, split data bus for the pads
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    // Requester side
    input  logic                     access,
    input  logic                     cmd_ready,
    output logic                     cmd_accepted,
    output logic                     cmd_done,
    input  logic                     wr_nrd,
    input  sdram_pkg::user_addr_t    addr,
    input  sdram_pkg::data_t         wr_data,
    output sdram_pkg::data_t         rd_data,
    // SDRAM pins
    output logic                     ncs,
    output logic                     nras,
    output logic                     ncas,
    output logic                     nwe,
    output logic [`SDRAM_ADDR_W-1:0] a,
    output sdram_pkg::bank_t         ba,
    output sdram_pkg::data_t         dq_out,
    output logic                     dq_oe,
    input  sdram_pkg::data_t         dq_in
);
    import sdram_pkg::*;

    user_addr_t cur_addr;
    data_t      cur_wr_data;
    sdram_cmd_t cmd;
    logic       row_miss;
    logic       refresh_pending;
    logic       refresh_start;
    logic       init_done;

    // -----------------------------------------------------------------------
    // Input side
    // -----------------------------------------------------------------------
    sdram_req_capture u_req_capture (
        .clk         (clk),
        .reset       (reset),
        .accept      (cmd_accepted),
        .addr        (addr),
        .wr_data     (wr_data),
        .cmd_ready   (cmd_ready),
        .cur_addr    (cur_addr),
        .cur_wr_data (cur_wr_data),
        .row_miss    (row_miss)
    );

    sdram_refresh_timer u_refresh_timer (
        .clk             (clk),
        .reset           (reset),
        .init_done       (init_done),
        .refresh_start   (refresh_start),
        .refresh_pending (refresh_pending)
    );

    sdram_ctrl_fsm u_fsm (
        .clk             (clk),
        .reset           (reset),
        .access          (access),
        .cmd_ready       (cmd_ready),
        .wr_nrd          (wr_nrd),
        .row_miss        (row_miss),
        .refresh_pending (refresh_pending),
        .cmd             (cmd),
        .cmd_accepted    (cmd_accepted),
        .refresh_start   (refresh_start),
        .init_done       (init_done)
    );

    // -----------------------------------------------------------------------
    // Output side
    // -----------------------------------------------------------------------
    sdram_cmd_encoder u_cmd_encoder (
        .cmd         (cmd),
        .req_addr    (addr),
        .cur_addr    (cur_addr),
        .cur_wr_data (cur_wr_data),
        .ncs         (ncs),
        .nras        (nras),
        .ncas        (ncas),
        .nwe         (nwe),
        .a           (a),
        .ba          (ba),
        .dq_out      (dq_out),
        .dq_oe       (dq_oe)
    );

    sdram_read_return u_read_return (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .dq_in    (dq_in),
        .rd_data  (rd_data),
        .cmd_done (cmd_done)
    );

endmodule

//--- sdram_model.sv
// ---------------------------------------------------------------------------
// Behavioral SDR part for the testbench; burst of one, no DQM, no CKE
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_model (
    input  logic                     clk,
    input  logic                     ncs,
    input  logic                     nras,
    input  logic                     ncas,
    input  logic                     nwe,
    input  logic [`SDRAM_ADDR_W-1:0] a,
    input  sdram_pkg::bank_t         ba,
    input  sdram_pkg::data_t         dq_out,
    input  logic                     dq_oe,
    output sdram_pkg::data_t         dq_in
);
    import sdram_pkg::*;

    sdram_cmd_t              cur_cmd;
    sdram_cmd_t              cmd_log[$];
    logic [`SDRAM_ADDR_W-1:0] a_log[$];
    bank_t                   ba_log[$];
    time                     time_log[$];
    int                      refresh_count = 0;
    int                      proto_errors = 0;
    logic [3:0]              bank_open = '0;
    row_t                    open_row[4];
    data_t                   mem[int];
    data_t                   rd_pipe[`SDRAM_CAS_LAT] = '{default: '0};

    function automatic sdram_cmd_t decode(logic [3:0] pins);
        casez (pins)
            4'b1???: return INHIBIT;
            4'b0011: return ACTIVE;
            4'b0101: return READ;
            4'b0100: return WRITE;
            4'b0010: return PRECHARGE_ALL;
            4'b0001: return AUTO_REFRESH;
            4'b0000: return LOAD_MODE;
            default: return NOP;
        endcase
    endfunction

    // Row, bank and column make the word key
    function automatic int word_key(bank_t b, logic [`SDRAM_ADDR_W-1:0] col);
        return int'({open_row[b], b, col[`SDRAM_COL_W-1:0]});
    endfunction

    // Unwritten words read a pattern built from the whole key
    function automatic data_t fill_word(int k);
        return data_t'(k[15:0] ^ {8'h00, k[23:16]});
    endfunction

    assign cur_cmd = decode({ncs, nras, ncas, nwe});
    assign dq_in   = rd_pipe[`SDRAM_CAS_LAT-1];

    always @(posedge clk) begin
        int k;
        for (int i = `SDRAM_CAS_LAT - 1; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= '0;
        if (cur_cmd != NOP && cur_cmd != INHIBIT) begin
            cmd_log.push_back(cur_cmd);
            a_log.push_back(a);
            ba_log.push_back(ba);
            time_log.push_back($time);
        end
        case (cur_cmd)
            ACTIVE: begin
                if (bank_open[ba]) begin
                    proto_errors++;
                    $display("Model: ACTIVE to bank %0d which already has a row open", ba);
                end
                bank_open[ba] = 1'b1;
                open_row[ba]  = row_t'(a);
            end
            READ, WRITE: begin
                if (!bank_open[ba]) begin
                    proto_errors++;
                    $display("Model: %s to bank %0d with no active row", cur_cmd.name(), ba);
                end else begin
                    k = word_key(ba, a);
                    if (cur_cmd == WRITE) begin
                        if (!dq_oe) begin
                            proto_errors++;
                            $display("Model: WRITE without the data bus driven");
                        end
                        mem[k] = dq_out;
                    end else begin
                        rd_pipe[0] <= mem.exists(k) ? mem[k] : fill_word(k);
                    end
                end
            end
            PRECHARGE_ALL: bank_open = '0;
            AUTO_REFRESH, LOAD_MODE: begin
                if (bank_open != '0) begin
                    proto_errors++;
                    $display("Model: %s while a bank is still open", cur_cmd.name());
                end
                if (cur_cmd == AUTO_REFRESH) begin
                    refresh_count++;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- sdram_ctrl_tb.sv
// ---------------------------------------------------------------------------
// Directed tests against the behavioral part; default macro timing assumed
// ---------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdram_ctrl_tb;
    import sdram_pkg::*;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     access;
    logic                     cmd_ready;
    logic                     cmd_accepted;
    logic                     cmd_done;
    logic                     wr_nrd;
    user_addr_t               addr;
    data_t                    wr_data;
    data_t                    rd_data;
    logic                     ncs;
    logic                     nras;
    logic                     ncas;
    logic                     nwe;
    logic [`SDRAM_ADDR_W-1:0] a;
    bank_t                    ba;
    data_t                    dq_out;
    logic                     dq_oe;
    data_t                    dq_in;

    int          check_errors = 0;
    int          timeout_errors = 0;
    logic [15:0] lfsr = 16'd50127;
    data_t       sb[user_addr_t];
    user_addr_t  written[$];

    always #50 clk = ~clk;

    sdram_ctrl i_dut (
        .clk(clk), .reset(reset), .access(access), .cmd_ready(cmd_ready),
        .cmd_accepted(cmd_accepted), .cmd_done(cmd_done), .wr_nrd(wr_nrd),
        .addr(addr), .wr_data(wr_data), .rd_data(rd_data), .ncs(ncs),
        .nras(nras), .ncas(ncas), .nwe(nwe), .a(a), .ba(ba),
        .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    sdram_model i_model (
        .clk(clk), .ncs(ncs), .nras(nras), .ncas(ncas), .nwe(nwe), .a(a),
        .ba(ba), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    // -----------------------------------------------------------------------
    // Random bits and compare tasks
    // -----------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cmd(string name, sdram_cmd_t got, sdram_cmd_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            check_errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // -----------------------------------------------------------------------
    // One access, with its accept and done timing checked
    // -----------------------------------------------------------------------
    task automatic do_access(input logic wr, input user_addr_t ad, input data_t wd,
                             output data_t rd, output logic ok);
        int n;
        ok = 1'b0;
        rd = '0;
        @(posedge clk);
        access    <= 1'b1;
        cmd_ready <= 1'b1;
        wr_nrd    <= wr;
        addr      <= ad;
        wr_data   <= wd;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cmd_accepted && n < 500);
        if (!cmd_accepted) begin
            timeout_errors++;
            $display("Timeout: no cmd_accepted for address %h", ad);
            @(posedge clk);
            cmd_ready <= 1'b0;
            return;
        end
        @(posedge clk);
        cmd_ready <= 1'b0;
        @(negedge clk);
        if (wr) begin
            check_cmd("pin command", i_model.cur_cmd, WRITE);
            check_count("cmd_done on WRITE", int'(cmd_done), 1);
            ok = 1'b1;
            return;
        end
        check_cmd("pin command", i_model.cur_cmd, READ);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cmd_done && n < 20);
        if (!cmd_done) begin
            timeout_errors++;
            $display("Timeout: no cmd_done for the read of address %h", ad);
            return;
        end
        check_count("read latency", n, `SDRAM_CAS_LAT);
        rd = rd_data;
        ok = 1'b1;
    endtask

    task automatic write_word(user_addr_t ad, data_t d);
        data_t rd;
        logic  ok;
        do_access(1'b1, ad, d, rd, ok);
        if (ok) begin
            if (!sb.exists(ad)) begin
                written.push_back(ad);
            end
            sb[ad] = d;
        end
    endtask

    task automatic read_check(user_addr_t ad);
        data_t rd;
        logic  ok;
        do_access(1'b0, ad, '0, rd, ok);
        if (ok) begin
            check_data("rd_data", rd, sb[ad]);
        end
    endtask

    // Returns once the model has seen a new AUTO_REFRESH
    task automatic wait_refresh();
        int r0;
        int n;
        r0 = i_model.refresh_count;
        n  = 0;
        while (i_model.refresh_count == r0 && n < 3 * `SDRAM_T_REFI) begin
            @(negedge clk);
            n++;
        end
        if (i_model.refresh_count == r0) begin
            timeout_errors++;
            $display("Timeout: no auto-refresh seen");
        end
    endtask

    function automatic int find_cmd(int from, sdram_cmd_t kind);
        for (int i = from; i < i_model.cmd_log.size(); i++) begin
            if (i_model.cmd_log[i] == kind) begin
                return i;
            end
        end
        return -1;
    endfunction

    // -----------------------------------------------------------------------
    // Directed tests
    // -----------------------------------------------------------------------
    task automatic test_init();
        int  n;
        time t0;
        t0 = $time;
        n  = 0;
        while (i_model.cmd_log.size() < 4 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (i_model.cmd_log.size() < 4) begin
            timeout_errors++;
            $display("Timeout: init sequence did not reach the pins");
            return;
        end
        check_cmd("init command 0", i_model.cmd_log[0], PRECHARGE_ALL);
        check_cmd("init command 1", i_model.cmd_log[1], AUTO_REFRESH);
        check_cmd("init command 2", i_model.cmd_log[2], AUTO_REFRESH);
        check_cmd("init command 3", i_model.cmd_log[3], LOAD_MODE);
        // Single write burst in bit 9, CAS latency in bits 6 to 4, the rest zero
        check_count("mode word on a", int'(i_model.a_log[3]),
                    (1 << 9) | (`SDRAM_CAS_LAT << 4));
        // Log times are sampling edges 100 ns apart
        if (i_model.time_log[0] - t0 < `SDRAM_T_INIT * 100) begin
            check_errors++;
            $display("Precharge-all came before the %0d-cycle power-up wait ended",
                     `SDRAM_T_INIT);
        end
    endtask

    task automatic test_write_read();
        write_word(24'h000123, 16'hA5C3);
        read_check(24'h000123);
    endtask

    task automatic test_row_hit();
        int idx;
        int n;
        wait_refresh();
        write_word(24'h012040, 16'h1357);
        idx = i_model.cmd_log.size();
        read_check(24'h012040);
        n = 0;
        for (int i = idx; i < i_model.cmd_log.size(); i++) begin
            if (i_model.cmd_log[i] inside {PRECHARGE_ALL, ACTIVE}) begin
                n++;
            end
        end
        check_count("row change commands on a hit", n, 0);
    endtask

    task automatic test_row_miss();
        user_addr_t addr_b;
        int         idx;
        int         p;
        int         act;
        addr_b = {13'd9, 2'd2, 9'd17};
        write_word({13'd5, 2'd1, 9'd3}, 16'hBEEF);
        idx = i_model.cmd_log.size();
        write_word(addr_b, 16'hCAFE);
        p   = find_cmd(idx, PRECHARGE_ALL);
        act = (p < 0) ? -1 : find_cmd(p, ACTIVE);
        if (act < 0) begin
            check_errors++;
            $display("Row miss was not followed by precharge-all and activate");
        end else begin
            check_count("ACTIVE row", int'(i_model.a_log[act]), 9);
            check_count("ACTIVE bank", int'(i_model.ba_log[act]), 2);
        end
        read_check({13'd5, 2'd1, 9'd3});
        read_check(addr_b);
    endtask

    task automatic test_refresh();
        int r0;
        int n;
        int idx;
        int r;
        @(posedge clk);
        access <= 1'b0;
        @(negedge clk);
        r0 = i_model.refresh_count;
        repeat (3 * `SDRAM_T_REFI) @(negedge clk);
        n = i_model.refresh_count - r0;
        if (n < 2 || n > 4) begin
            check_errors++;
            $display("Idle refresh count %0d is outside 2 to 4", n);
        end
        read_check(written[0]);
        idx = i_model.cmd_log.size();
        // Access stays high here, so the row must be closed for refresh
        wait_refresh();
        r = find_cmd(idx, AUTO_REFRESH);
        if (r < 0 || find_cmd(idx, PRECHARGE_ALL) < 0 || find_cmd(idx, PRECHARGE_ALL) > r) begin
            check_errors++;
            $display("Open row was not precharged before the refresh");
        end
    endtask

    task automatic test_random();
        logic [31:0] v;
        user_addr_t  ad;
        for (int i = 0; i < 40; i++) begin
            v = rand_bits(1);
            if (v[0] || written.size() == 0) begin
                v  = rand_bits(24);
                ad = v[23:0];
                v  = rand_bits(16);
                write_word(ad, v[15:0]);
            end else begin
                v = rand_bits(5);
                read_check(written[v % written.size()]);
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        access    = 1'b0;
        cmd_ready = 1'b0;
        wr_nrd    = 1'b0;
        addr      = '0;
        wr_data   = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_init();
        test_write_read();
        test_row_hit();
        test_row_miss();
        test_refresh();
        test_random();
        @(posedge clk);
        access <= 1'b0;
        repeat (10) @(posedge clk);
        $display("Errors: %0d check, %0d timeout, %0d protocol",
                 check_errors, timeout_errors, i_model.proto_errors);
        if (check_errors == 0 && timeout_errors == 0 && i_model.proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
sdram_pkg.sv
sdram_req_capture.sv
sdram_refresh_timer.sv
sdram_ctrl_fsm.sv
sdram_cmd_encoder.sv
sdram_read_return.sv
sdram_ctrl.sv
sdram_model.sv
sdram_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sdram_ctrl_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)
